// File: design/gpu_pkg.sv
// GPU core package with bus and pixel widths, register map, job action type and line job struct
package gpu_pkg;

  // Local bus and register widths
  localparam int P_32B_W  = 32;
  localparam int P_16B_W  = 16;
  localparam int P_ADDR_W = 8;

  // Screen coordinate widths
  localparam int P_X_W = 10;
  localparam int P_Y_W = 9;

  // Colour is luma plus two chroma fields
  localparam int P_LUM_W   = 8;
  localparam int P_CHRM_W  = 4;
  localparam int P_COLOR_W = P_LUM_W + P_CHRM_W + P_CHRM_W;

  // Register map
  // Enable in bit 0
  localparam logic [P_ADDR_W-1:0] GPU_CONTROL_REG_ADDR    = 8'h00;
  // Busy in bit 0, read only
  localparam logic [P_ADDR_W-1:0] GPU_STATUS_REG_ADDR     = 8'h01;
  // Writing here issues the job
  localparam logic [P_ADDR_W-1:0] GPU_JOB_ACTION_REG_ADDR = 8'h02;
  localparam logic [P_ADDR_W-1:0] GPU_JOB_X0_REG_ADDR     = 8'h03;
  localparam logic [P_ADDR_W-1:0] GPU_JOB_Y0_REG_ADDR     = 8'h04;
  localparam logic [P_ADDR_W-1:0] GPU_JOB_X1_REG_ADDR     = 8'h05;
  localparam logic [P_ADDR_W-1:0] GPU_JOB_Y1_REG_ADDR     = 8'h06;
  localparam logic [P_ADDR_W-1:0] GPU_JOB_COLOR_REG_ADDR  = 8'h07;

  // Read data for any address outside the map
  localparam logic [P_32B_W-1:0] GPU_UNMAPPED_RD_DATA = 32'hdeadbabe;

  // Job action codes
  // FILL is reserved, no engine behind it
  typedef enum logic [1:0]
  {
    DRAW = 2'd0,
    FILL = 2'd1,
    NOP  = 2'd2
  } action_t;

  // Line job, 54 bits
  typedef struct packed
  {
    logic [P_X_W-1:0]     x0;
    logic [P_Y_W-1:0]     y0;
    logic [P_X_W-1:0]     x1;
    logic [P_Y_W-1:0]     y1;
    logic [P_COLOR_W-1:0] color;
  } line_job_t;

endpackage

// File: design/gpu_job_intf.sv
// Job link carrying the start pulse, line job and busy level between register block and engine
`timescale 1ns/1ps

interface gpu_job_intf
  import gpu_pkg::*;
();

  // One cycle start pulse
  logic      job_start;
  // Job fields, already cut to coordinate widths
  line_job_t job;
  // High from job accept until last pixel taken
  logic      busy;

  // Register block side
  modport regs
  (
    output job_start,
    output job,
    input  busy
  );

  // Line engine side, start only taken while idle
  modport engine
  (
    input  job_start,
    input  job,
    output busy
  );

endinterface

// File: design/gpu_core_regs.sv
// Local bus register block holding control, status and line job registers and issuing job starts
`timescale 1ns/1ps

module gpu_core_regs
  import gpu_pkg::*;
(
  input  logic                cr_intf,
  input  logic                arst_n,
  input  logic                lb_wr_en,
  input  logic                lb_rd_en,
  input  logic [P_ADDR_W-1:0] lb_addr,
  input  logic [P_32B_W-1:0]  lb_wr_data,
  output logic                lb_wr_valid,
  output logic                lb_rd_valid,
  output logic [P_32B_W-1:0]  lb_rd_data,
  gpu_job_intf.regs           job_intf
);

  // Control and job registers
  logic               en_f;
  action_t            action_f;
  logic [P_16B_W-1:0] x0_f;
  logic [P_16B_W-1:0] y0_f;
  logic [P_16B_W-1:0] x1_f;
  logic [P_16B_W-1:0] y1_f;
  logic [P_16B_W-1:0] color_f;

  // Action write seen on previous edge
  logic               act_wr_f;
  logic               job_start_f;

  // Write decode
  always_ff @(posedge cr_intf or negedge arst_n)
  begin
    if (!arst_n)
    begin
      en_f        <= 1'b0;
      action_f    <= DRAW;
      x0_f        <= '0;
      y0_f        <= '0;
      x1_f        <= '0;
      y1_f        <= '0;
      color_f     <= '0;
      act_wr_f    <= 1'b0;
      job_start_f <= 1'b0;
      lb_wr_valid <= 1'b0;
    end
    else
    begin
      if (lb_wr_en)
      begin
        case (lb_addr)
          GPU_CONTROL_REG_ADDR    : en_f     <= lb_wr_data[0];
          GPU_JOB_ACTION_REG_ADDR : action_f <= action_t'(lb_wr_data[1:0]);
          GPU_JOB_X0_REG_ADDR     : x0_f     <= lb_wr_data[P_16B_W-1:0];
          GPU_JOB_Y0_REG_ADDR     : y0_f     <= lb_wr_data[P_16B_W-1:0];
          GPU_JOB_X1_REG_ADDR     : x1_f     <= lb_wr_data[P_16B_W-1:0];
          GPU_JOB_Y1_REG_ADDR     : y1_f     <= lb_wr_data[P_16B_W-1:0];
          GPU_JOB_COLOR_REG_ADDR  : color_f  <= lb_wr_data[P_16B_W-1:0];
          // Status and unmapped writes dropped
          default                 : ;
        endcase
      end

      lb_wr_valid <= lb_wr_en;

      // Stage 1, remember the action write
      act_wr_f    <= lb_wr_en && (lb_addr == GPU_JOB_ACTION_REG_ADDR);
      // Stage 2, qualify with the now stored action and enable
      job_start_f <= act_wr_f && (action_f == DRAW) && en_f;
    end
  end

  // Read path, data lands one cycle after the strobe
  always_ff @(posedge cr_intf or negedge arst_n)
  begin
    if (!arst_n)
    begin
      lb_rd_valid <= 1'b0;
      lb_rd_data  <= '0;
    end
    else
    begin
      lb_rd_valid <= lb_rd_en;
      if (lb_rd_en)
      begin
        case (lb_addr)
          GPU_CONTROL_REG_ADDR    : lb_rd_data <= {{(P_32B_W-1){1'b0}}, en_f};
          GPU_STATUS_REG_ADDR     : lb_rd_data <= {{(P_32B_W-1){1'b0}}, job_intf.busy};
          GPU_JOB_ACTION_REG_ADDR : lb_rd_data <= {{(P_32B_W-2){1'b0}}, action_f};
          GPU_JOB_X0_REG_ADDR     : lb_rd_data <= {{(P_32B_W-P_16B_W){1'b0}}, x0_f};
          GPU_JOB_Y0_REG_ADDR     : lb_rd_data <= {{(P_32B_W-P_16B_W){1'b0}}, y0_f};
          GPU_JOB_X1_REG_ADDR     : lb_rd_data <= {{(P_32B_W-P_16B_W){1'b0}}, x1_f};
          GPU_JOB_Y1_REG_ADDR     : lb_rd_data <= {{(P_32B_W-P_16B_W){1'b0}}, y1_f};
          GPU_JOB_COLOR_REG_ADDR  : lb_rd_data <= {{(P_32B_W-P_16B_W){1'b0}}, color_f};
          default                 : lb_rd_data <= GPU_UNMAPPED_RD_DATA;
        endcase
      end
    end
  end

  // Job fields cut to package widths
  assign job_intf.job = line_job_t'{
    x0    : x0_f[P_X_W-1:0],
    y0    : y0_f[P_Y_W-1:0],
    x1    : x1_f[P_X_W-1:0],
    y1    : y1_f[P_Y_W-1:0],
    color : color_f[P_COLOR_W-1:0]
  };

  assign job_intf.job_start = job_start_f;

endmodule

// File: design/gpu_line_engine.sv
// Bresenham line engine streaming one pixel per cycle under valid and ready back-pressure
`timescale 1ns/1ps

module gpu_line_engine
  import gpu_pkg::*;
(
  input  logic                 cr_intf,
  input  logic                 arst_n,
  gpu_job_intf.engine          job_intf,
  input  logic                 pxl_ready,
  output logic                 pxl_valid,
  output logic                 pxl_last,
  output logic [P_X_W-1:0]     pxl_posx,
  output logic [P_Y_W-1:0]     pxl_posy,
  output logic [P_COLOR_W-1:0] pxl_color
);

  // Job in flight, doubles as stream valid
  logic                    busy_f;

  // Current pixel and end point
  logic [P_X_W-1:0]        cur_x_f;
  logic [P_Y_W-1:0]        cur_y_f;
  logic [P_X_W-1:0]        end_x_f;
  logic [P_Y_W-1:0]        end_y_f;
  logic [P_COLOR_W-1:0]    color_f;

  // Bresenham state, two extra bits for sign and headroom
  logic signed [P_X_W+1:0] dx_f;
  logic signed [P_X_W+1:0] dy_f;
  logic signed [P_X_W+1:0] err_f;
  // Step direction, high means decrement
  logic                    sx_f;
  logic                    sy_f;

  // Setup terms from the incoming job
  logic [P_X_W-1:0]        abs_dx;
  logic [P_Y_W-1:0]        abs_dy;
  logic signed [P_X_W+1:0] dx_init;
  logic signed [P_X_W+1:0] dy_init;

  // Step decision
  logic signed [P_X_W+2:0] e2;
  logic signed [P_X_W+2:0] dx_ext;
  logic signed [P_X_W+2:0] dy_ext;
  logic signed [P_X_W+1:0] add_x;
  logic signed [P_X_W+1:0] add_y;
  logic                    step_x;
  logic                    step_y;

  logic                    start;
  logic                    accept;
  logic                    at_end;

  // Start only honoured while idle
  assign start  = job_intf.job_start && !busy_f;
  assign accept = busy_f && pxl_ready;
  assign at_end = (cur_x_f == end_x_f) && (cur_y_f == end_y_f);

  // Absolute deltas from the job
  always_comb
  begin
    if (job_intf.job.x1 >= job_intf.job.x0)
      abs_dx = job_intf.job.x1 - job_intf.job.x0;
    else
      abs_dx = job_intf.job.x0 - job_intf.job.x1;

    if (job_intf.job.y1 >= job_intf.job.y0)
      abs_dy = job_intf.job.y1 - job_intf.job.y0;
    else
      abs_dy = job_intf.job.y0 - job_intf.job.y1;
  end

  // dx positive, dy negated
  assign dx_init = $signed({2'b00, abs_dx});
  assign dy_init = -$signed({{(P_X_W+2-P_Y_W){1'b0}}, abs_dy});

  // e2 is twice the error, one bit wider
  assign e2     = $signed({err_f, 1'b0});
  assign dx_ext = $signed({dx_f[P_X_W+1], dx_f});
  assign dy_ext = $signed({dy_f[P_X_W+1], dy_f});
  assign step_x = (e2 >= dy_ext);
  assign step_y = (e2 <= dx_ext);
  assign add_x  = step_x ? dy_f : '0;
  assign add_y  = step_y ? dx_f : '0;

  // Job state
  always_ff @(posedge cr_intf or negedge arst_n)
  begin
    if (!arst_n)
      busy_f <= 1'b0;
    else if (start)
      busy_f <= 1'b1;
    // Drops on the edge after the last pixel is taken
    else if (accept && at_end)
      busy_f <= 1'b0;
  end

  // Pixel walk
  always_ff @(posedge cr_intf)
  begin
    if (start)
    begin
      // Latched copy, job regs free to change
      cur_x_f <= job_intf.job.x0;
      cur_y_f <= job_intf.job.y0;
      end_x_f <= job_intf.job.x1;
      end_y_f <= job_intf.job.y1;
      color_f <= job_intf.job.color;
      dx_f    <= dx_init;
      dy_f    <= dy_init;
      err_f   <= dx_init + dy_init;
      sx_f    <= (job_intf.job.x1 < job_intf.job.x0);
      sy_f    <= (job_intf.job.y1 < job_intf.job.y0);
    end
    else if (accept && !at_end)
    begin
      err_f <= err_f + add_x + add_y;
      if (step_x)
        cur_x_f <= sx_f ? cur_x_f - 1'b1 : cur_x_f + 1'b1;
      if (step_y)
        cur_y_f <= sy_f ? cur_y_f - 1'b1 : cur_y_f + 1'b1;
    end
  end

  // Outputs straight from state, so they hold while stalled
  assign pxl_valid     = busy_f;
  assign pxl_last      = busy_f && at_end;
  assign pxl_posx      = cur_x_f;
  assign pxl_posy      = cur_y_f;
  assign pxl_color     = color_f;
  assign job_intf.busy = busy_f;

endmodule

// File: design/gpu_core.sv
// GPU core top level joining the register block and the line engine over the job link
`timescale 1ns/1ps

module gpu_core
  import gpu_pkg::*;
(
  input  logic                 cr_intf,
  input  logic                 arst_n,

  // Local bus
  input  logic                 lb_wr_en,
  input  logic                 lb_rd_en,
  input  logic [P_ADDR_W-1:0]  lb_addr,
  input  logic [P_32B_W-1:0]   lb_wr_data,
  output logic                 lb_wr_valid,
  output logic                 lb_rd_valid,
  output logic [P_32B_W-1:0]   lb_rd_data,

  // Pixel stream
  input  logic                 pxl_ready,
  output logic                 pxl_valid,
  output logic                 pxl_last,
  output logic [P_X_W-1:0]     pxl_posx,
  output logic [P_Y_W-1:0]     pxl_posy,
  output logic [P_COLOR_W-1:0] pxl_color
);

  // Job link
  gpu_job_intf job_intf();

  // Registers and start pulse
  gpu_core_regs gpu_core_regs_inst
  (
    .cr_intf     (cr_intf),
    .arst_n      (arst_n),
    .lb_wr_en    (lb_wr_en),
    .lb_rd_en    (lb_rd_en),
    .lb_addr     (lb_addr),
    .lb_wr_data  (lb_wr_data),
    .lb_wr_valid (lb_wr_valid),
    .lb_rd_valid (lb_rd_valid),
    .lb_rd_data  (lb_rd_data),
    .job_intf    (job_intf.regs)
  );

  // Line rasterizer
  gpu_line_engine gpu_line_engine_inst
  (
    .cr_intf   (cr_intf),
    .arst_n    (arst_n),
    .job_intf  (job_intf.engine),
    .pxl_ready (pxl_ready),
    .pxl_valid (pxl_valid),
    .pxl_last  (pxl_last),
    .pxl_posx  (pxl_posx),
    .pxl_posy  (pxl_posy),
    .pxl_color (pxl_color)
  );

endmodule

// File: verif/gpu_core_sva.sv
// GPU core checks on bus response timing, pixel hold under stall and busy state in reset
`timescale 1ns/1ps

module gpu_core_sva
  import gpu_pkg::*;
(
  input logic                 cr_intf,
  input logic                 arst_n,
  input logic                 lb_wr_en,
  input logic                 lb_rd_en,
  input logic                 lb_wr_valid,
  input logic                 lb_rd_valid,
  input logic                 busy,
  input logic                 pxl_ready,
  input logic                 pxl_valid,
  input logic                 pxl_last,
  input logic [P_X_W-1:0]     pxl_posx,
  input logic [P_Y_W-1:0]     pxl_posy,
  input logic [P_COLOR_W-1:0] pxl_color
);

  // Failed assertions so far, summed into the run result
  int fail_cnt = 0;

  // Write response one cycle after the strobe
  wr_valid_timing: assert property (@(posedge cr_intf) disable iff (!arst_n)
    lb_wr_valid == $past(lb_wr_en))
  else
  begin
    fail_cnt++;
    $error("lb_wr_valid not one cycle after lb_wr_en");
  end

  // Read response one cycle after the strobe
  rd_valid_timing: assert property (@(posedge cr_intf) disable iff (!arst_n)
    lb_rd_valid == $past(lb_rd_en))
  else
  begin
    fail_cnt++;
    $error("lb_rd_valid not one cycle after lb_rd_en");
  end

  // Stalled pixel holds
  pxl_hold: assert property (@(posedge cr_intf) disable iff (!arst_n)
    pxl_valid && !pxl_ready |=>
      pxl_valid && $stable({pxl_last, pxl_posx, pxl_posy, pxl_color}))
  else
  begin
    fail_cnt++;
    $error("pixel stream changed while stalled");
  end

  // Engine idle through reset
  busy_in_reset: assert property (@(posedge cr_intf) !arst_n |-> !busy)
  else
  begin
    fail_cnt++;
    $error("engine busy during reset");
  end

endmodule

bind gpu_core gpu_core_sva gpu_core_sva_inst
(
  .cr_intf     (cr_intf),
  .arst_n      (arst_n),
  .lb_wr_en    (lb_wr_en),
  .lb_rd_en    (lb_rd_en),
  .lb_wr_valid (lb_wr_valid),
  .lb_rd_valid (lb_rd_valid),
  .busy        (job_intf.busy),
  .pxl_ready   (pxl_ready),
  .pxl_valid   (pxl_valid),
  .pxl_last    (pxl_last),
  .pxl_posx    (pxl_posx),
  .pxl_posy    (pxl_posy),
  .pxl_color   (pxl_color)
);

// File: verif/gpu_core_tb.sv
// GPU core testbench driving random register traffic and line jobs against reference models
`timescale 1ns/1ps

module gpu_core_tb
  import gpu_pkg::*;
();

  // Longest line at quarter rate plus setup, per job
  localparam int N_JOBS      = 40;
  localparam int CYCLE_LIMIT = N_JOBS * (513 * 4 + 20);

  // One pixel of the line model
  typedef struct packed
  {
    logic [P_X_W-1:0] x;
    logic [P_Y_W-1:0] y;
    logic             last;
  } exp_pxl_t;

  logic                 cr_intf;
  logic                 arst_n;
  logic                 lb_wr_en;
  logic                 lb_rd_en;
  logic [P_ADDR_W-1:0]  lb_addr;
  logic [P_32B_W-1:0]   lb_wr_data;
  logic                 lb_wr_valid;
  logic                 lb_rd_valid;
  logic [P_32B_W-1:0]   lb_rd_data;
  logic                 pxl_ready;
  logic                 pxl_valid;
  logic                 pxl_last;
  logic [P_X_W-1:0]     pxl_posx;
  logic [P_Y_W-1:0]     pxl_posy;
  logic [P_COLOR_W-1:0] pxl_color;

  int                   seed = 58;
  int                   val_errs = 0;
  int                   proto_errs = 0;
  int                   cycle_cnt = 0;
  int                   stall_cnt = 0;
  // Register model, index is the bus address
  logic [P_32B_W-1:0]   reg_model [0:7];
  // Pixels still owed by the engine
  exp_pxl_t             exp_q [$];
  logic [P_COLOR_W-1:0] exp_color;

  gpu_core gpu_core_inst (.*);

  // 8 ns clock
  initial cr_intf = 1'b0;
  always #4 cr_intf = ~cr_intf;

  task automatic check_rd_data(input string name, input logic [P_32B_W-1:0] exp_val,
                               input logic [P_32B_W-1:0] act_val);
    if (act_val !== exp_val)
    begin
      $display("FAIL %s expected %08h actual %08h", name, exp_val, act_val);
      val_errs++;
    end
  endtask

  task automatic check_pxl(input string name,
                           input logic [P_X_W-1:0]     exp_x,
                           input logic [P_Y_W-1:0]     exp_y,
                           input logic [P_COLOR_W-1:0] exp_c,
                           input logic [P_X_W-1:0]     act_x,
                           input logic [P_Y_W-1:0]     act_y,
                           input logic [P_COLOR_W-1:0] act_c);
    if ({act_x, act_y, act_c} !== {exp_x, exp_y, exp_c})
    begin
      $display("FAIL %s expected (%0d,%0d,%04h) actual (%0d,%0d,%04h)",
               name, exp_x, exp_y, exp_c, act_x, act_y, act_c);
      val_errs++;
    end
  endtask

  // Reference Bresenham walk, queues every pixel of the line
  task automatic push_line(input int x0, input int y0, input int x1, input int y1);
    int       dx;
    int       dy;
    int       sx;
    int       sy;
    int       err;
    int       e2;
    exp_pxl_t p;
    dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
    // Negative magnitude
    dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
    sx  = (x0 < x1) ? 1 : -1;
    sy  = (y0 < y1) ? 1 : -1;
    err = dx + dy;
    p.last = 1'b0;
    while (!p.last)
    begin
      p.x    = x0[P_X_W-1:0];
      p.y    = y0[P_Y_W-1:0];
      p.last = (x0 == x1) && (y0 == y1);
      exp_q.push_back(p);
      e2 = 2 * err;
      if (e2 >= dy)
      begin
        err += dy;
        x0  += sx;
      end
      if (e2 <= dx)
      begin
        err += dx;
        y0  += sy;
      end
    end
  endtask

  // Bus write with response check, then model update
  task automatic write_reg(input logic [P_ADDR_W-1:0] addr, input logic [P_32B_W-1:0] data);
    lb_wr_en   <= 1'b1;
    lb_addr    <= addr;
    lb_wr_data <= data;
    @(posedge cr_intf);
    lb_wr_en   <= 1'b0;
    @(posedge cr_intf);
    if (lb_wr_valid !== 1'b1)
    begin
      $display("ERROR: no write valid one cycle after the write to address %02h", addr);
      proto_errs++;
    end
    // Enable is 1 bit, action 2 bits, job registers 16 bits
    if (addr == GPU_CONTROL_REG_ADDR)
      reg_model[0] = data & 32'h1;
    else if (addr == GPU_JOB_ACTION_REG_ADDR)
      reg_model[2] = data & 32'h3;
    else if (addr > GPU_JOB_ACTION_REG_ADDR && addr <= GPU_JOB_COLOR_REG_ADDR)
      reg_model[addr[2:0]] = data & 32'hffff;
    // DRAW while enabled and idle starts a line
    if (addr == GPU_JOB_ACTION_REG_ADDR && data[1:0] == DRAW && reg_model[0][0] &&
        exp_q.size() == 0)
    begin
      exp_color = reg_model[7][P_COLOR_W-1:0];
      push_line(int'(reg_model[3][P_X_W-1:0]), int'(reg_model[4][P_Y_W-1:0]),
                int'(reg_model[5][P_X_W-1:0]), int'(reg_model[6][P_Y_W-1:0]));
    end
  endtask

  // Bus read, data due exactly one cycle after the strobe
  task automatic read_check(input string name, input logic [P_ADDR_W-1:0] addr,
                            input logic [P_32B_W-1:0] exp_val);
    lb_rd_en <= 1'b1;
    lb_addr  <= addr;
    @(posedge cr_intf);
    lb_rd_en <= 1'b0;
    @(posedge cr_intf);
    if (lb_rd_valid !== 1'b1)
    begin
      $display("ERROR: no read valid one cycle after the read of address %02h", addr);
      proto_errs++;
    end
    check_rd_data(name, exp_val, lb_rd_data);
  endtask

  task automatic load_job(input int x0, input int y0, input int x1, input int y1, input int c);
    write_reg(GPU_JOB_X0_REG_ADDR, x0);
    write_reg(GPU_JOB_Y0_REG_ADDR, y0);
    write_reg(GPU_JOB_X1_REG_ADDR, x1);
    write_reg(GPU_JOB_Y1_REG_ADDR, y1);
    write_reg(GPU_JOB_COLOR_REG_ADDR, c);
  endtask

  // Model queue drained, then busy gets its edge to fall
  task automatic wait_idle();
    while (exp_q.size() != 0)
      @(posedge cr_intf);
    repeat (2) @(posedge cr_intf);
  endtask

  // Action write that must not start the engine
  task automatic expect_no_start(input string name, input logic en, input action_t act);
    write_reg(GPU_CONTROL_REG_ADDR, {31'b0, en});
    write_reg(GPU_JOB_ACTION_REG_ADDR, {30'b0, act});
    repeat (20) @(posedge cr_intf);
    read_check(name, GPU_STATUS_REG_ADDR, 32'h0);
  endtask

  task automatic finish_run();
    int sva_errs;
    sva_errs = gpu_core_inst.gpu_core_sva_inst.fail_cnt;
    $display("Errors: %0d value, %0d protocol, %0d assertion", val_errs, proto_errs, sva_errs);
    if (val_errs + proto_errs + sva_errs == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Sink ready near 70 percent, with occasional long stalls
  always @(posedge cr_intf)
  begin
    if (stall_cnt > 0)
    begin
      pxl_ready <= 1'b0;
      stall_cnt <= stall_cnt - 1;
    end
    else if ($unsigned($random(seed)) % 32 == 0)
    begin
      pxl_ready <= 1'b0;
      stall_cnt <= $unsigned($random(seed)) % 12;
    end
    else
      pxl_ready <= ($unsigned($random(seed)) % 10) < 7;
  end

  // Every accepted pixel against the model queue
  always @(posedge cr_intf)
  begin
    exp_pxl_t e;
    if (arst_n && pxl_valid && pxl_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("ERROR: pixel (%0d,%0d) accepted with no line expected", pxl_posx, pxl_posy);
        proto_errs++;
      end
      else
      begin
        e = exp_q.pop_front();
        check_pxl("line_pixel", e.x, e.y, exp_color, pxl_posx, pxl_posy, pxl_color);
        if (pxl_last !== e.last)
        begin
          $display("FAIL line_last expected %b actual %b at (%0d,%0d)",
                   e.last, pxl_last, pxl_posx, pxl_posy);
          val_errs++;
        end
      end
    end
  end

  // Hang guard
  always @(posedge cr_intf)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("ERROR: timeout, run still going after %0d cycles", CYCLE_LIMIT);
      proto_errs++;
      finish_run();
    end
  end

  initial
  begin
    int i;
    int a;
    int x0;
    int y0;
    int x1;
    int y1;
    arst_n     = 1'b0;
    lb_wr_en   = 1'b0;
    lb_rd_en   = 1'b0;
    lb_addr    = '0;
    lb_wr_data = '0;
    pxl_ready  = 1'b0;
    for (i = 0; i < 8; i++)
      reg_model[i[2:0]] = '0;
    repeat (16) @(posedge cr_intf);
    arst_n <= 1'b1;
    @(posedge cr_intf);

    // Readback, enable low while the action is written
    repeat (4)
    begin
      write_reg(GPU_CONTROL_REG_ADDR, 32'h0);
      for (i = 2; i < 8; i++)
        write_reg(i[P_ADDR_W-1:0], $random(seed));
      write_reg(GPU_CONTROL_REG_ADDR, $random(seed));
      for (i = 0; i < 8; i++)
        read_check("reg_readback", i[P_ADDR_W-1:0], reg_model[i[2:0]]);
    end

    // Unmapped space and idle status
    repeat (16)
    begin
      a = 8 + $unsigned($random(seed)) % 248;
      read_check("unmapped_read", a[P_ADDR_W-1:0], GPU_UNMAPPED_RD_DATA);
    end
    read_check("status_idle", GPU_STATUS_REG_ADDR, 32'h0);

    // Gating on enable and action code
    load_job(3, 4, 40, 30, 16'h1234);
    expect_no_start("gate_disabled", 1'b0, DRAW);
    expect_no_start("gate_fill", 1'b1, FILL);
    expect_no_start("gate_nop", 1'b1, NOP);

    // Long line, busy status, job rewrite and second start dropped
    load_job(0, 10, 512, 300, 16'hbeef);
    write_reg(GPU_JOB_ACTION_REG_ADDR, 32'h0);
    repeat (8) @(posedge cr_intf);
    read_check("status_busy", GPU_STATUS_REG_ADDR, 32'h1);
    write_reg(GPU_JOB_X0_REG_ADDR, 32'd5);
    write_reg(GPU_JOB_ACTION_REG_ADDR, 32'h0);
    wait_idle();
    read_check("status_done", GPU_STATUS_REG_ADDR, 32'h0);

    // Random lines over all octants, every eighth one a single point
    for (i = 0; i < 30; i++)
    begin
      x0 = $unsigned($random(seed)) % 513;
      y0 = $unsigned($random(seed)) % 512;
      x1 = $unsigned($random(seed)) % 513;
      y1 = $unsigned($random(seed)) % 512;
      if (i % 8 == 0)
      begin
        x1 = x0;
        y1 = y0;
      end
      load_job(x0, y0, x1, y1, $random(seed));
      write_reg(GPU_JOB_ACTION_REG_ADDR, 32'h0);
      wait_idle();
    end
    read_check("status_final", GPU_STATUS_REG_ADDR, 32'h0);

    finish_run();
  end

endmodule

// File: build.f
design/gpu_pkg.sv
design/gpu_job_intf.sv
design/gpu_core_regs.sv
design/gpu_line_engine.sv
design/gpu_core.sv
verif/gpu_core_sva.sv
verif/gpu_core_tb.sv

// File: Makefile
# Verilator build and run of the GPU core testbench

VERILATOR ?= verilator
TOP       ?= gpu_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
